// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and address width
`define DATA_W    32

// Register file geometry
`define REG_AW    5
`define NUM_REGS  32

// Opcode sits in the top four bits
`define OPC_MSB   31
`define OPC_LSB   28

// Register fields, five bits each, below the opcode
`define RD_LSB    23
`define RS1_LSB   18
`define RS2_LSB   13

// Sign-extended immediate in the low bits
`define IMM_W     12

`endif

// File: rtl/core_pkg.sv
package core_pkg;

`include "core_defs.svh"

    // Instruction opcodes
    typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LW   = 4'd7,
        OP_SW   = 4'd8
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // What an instruction does once it leaves decode
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_alu_wen;
        logic    reg_mem_wen;
        logic    mem_we;
        logic    mem_en;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{alu_op: ALU_ADD, default: 1'b0};

endpackage

// File: rtl/bus_pkg.sv
package bus_pkg;

    // Wishbone classic master sequencing
    typedef enum logic [1:0] {
        WBM_IDLE,
        WBM_BUSY,
        WBM_DONE
    } wbm_state_e;

    // Kind of access the memory stage must run
    typedef enum logic [1:0] {
        BUS_NONE,
        BUS_READ,
        BUS_WRITE
    } bus_kind_e;

endpackage

// File: rtl/stage_if.sv
`timescale 1ns/10ps
`include "core_defs.svh"

// Decode to execute bundle
interface id_ex_if import core_pkg::*; ();
    logic               valid;
    ctrl_t              ctrl;
    logic [`REG_AW-1:0] rd_addr;
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic [`DATA_W-1:0] rs1_data;
    logic [`DATA_W-1:0] rs2_data;
    logic [`DATA_W-1:0] imm;

    modport producer (
        output valid, ctrl, rd_addr, rs1_addr, rs2_addr, rs1_data, rs2_data, imm
    );
    modport consumer (
        input  valid, ctrl, rd_addr, rs1_addr, rs2_addr, rs1_data, rs2_data, imm
    );
endinterface

// Execute to memory bundle
interface ex_mem_if import core_pkg::*; ();
    logic               valid;
    ctrl_t              ctrl;
    logic [`REG_AW-1:0] rd_addr;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] store_data;

    modport producer (
        output valid, ctrl, rd_addr, alu_result, store_data
    );
    modport consumer (
        input  valid, ctrl, rd_addr, alu_result, store_data
    );
endinterface

// File: rtl/decode_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module decode_stage import core_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Instruction input
    input  logic [`DATA_W-1:0] instr_i,
    input  logic               instr_valid_i,
    output logic               instr_ready_o,
    // Freeze from the memory stage
    input  logic               hold_i,
    // Register file write from write-back
    input  logic               rf_we_i,
    input  logic [`REG_AW-1:0] rf_waddr_i,
    input  logic [`DATA_W-1:0] rf_wdata_i,
    // Instruction currently in execute
    input  logic [`REG_AW-1:0] ex_mem_rd_i,
    input  logic               ex_is_load_i,
    id_ex_if.producer          id_ex
);

    logic [`DATA_W-1:0] instr_q;
    logic               instr_vld_q;
    logic [`DATA_W-1:0] regs [`NUM_REGS];

    opcode_e            opcode;
    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`DATA_W-1:0] imm;
    logic [`DATA_W-1:0] rs1_data;
    logic [`DATA_W-1:0] rs2_data;
    ctrl_t              ctrl;
    logic               uses_rs2;
    logic               stall;

    ////////////////////
    // Decode
    ////////////////////

    assign opcode = opcode_e'(instr_q[`OPC_MSB:`OPC_LSB]);
    assign rd     = instr_q[`RD_LSB  +: `REG_AW];
    assign rs1    = instr_q[`RS1_LSB +: `REG_AW];
    assign rs2    = instr_q[`RS2_LSB +: `REG_AW];
    assign imm    = {{(`DATA_W-`IMM_W){instr_q[`IMM_W-1]}}, instr_q[`IMM_W-1:0]};

    always_comb begin
        case (opcode)
            OP_ADD:  ctrl = '{alu_op: ALU_ADD, reg_alu_wen: 1'b1, default: 1'b0};
            OP_SUB:  ctrl = '{alu_op: ALU_SUB, reg_alu_wen: 1'b1, default: 1'b0};
            OP_AND:  ctrl = '{alu_op: ALU_AND, reg_alu_wen: 1'b1, default: 1'b0};
            OP_OR:   ctrl = '{alu_op: ALU_OR,  reg_alu_wen: 1'b1, default: 1'b0};
            OP_XOR:  ctrl = '{alu_op: ALU_XOR, reg_alu_wen: 1'b1, default: 1'b0};
            OP_ADDI: ctrl = '{alu_op: ALU_ADD, use_imm: 1'b1, reg_alu_wen: 1'b1, default: 1'b0};
            OP_LW:   ctrl = '{alu_op: ALU_ADD, use_imm: 1'b1, reg_mem_wen: 1'b1,
                              mem_en: 1'b1, default: 1'b0};
            OP_SW:   ctrl = '{alu_op: ALU_ADD, use_imm: 1'b1, mem_we: 1'b1,
                              mem_en: 1'b1, default: 1'b0};
            default: ctrl = CTRL_NOP;
        endcase
        // Results aimed at x0 are dropped here
        if (rd == '0) begin
            ctrl.reg_alu_wen = 1'b0;
            ctrl.reg_mem_wen = 1'b0;
        end
    end

    // Register file read with write-through
    always_comb begin
        rs1_data = regs[rs1];
        rs2_data = regs[rs2];
        if (rf_we_i && rf_waddr_i == rs1) begin
            rs1_data = rf_wdata_i;
        end
        if (rf_we_i && rf_waddr_i == rs2) begin
            rs2_data = rf_wdata_i;
        end
        if (rs1 == '0) begin
            rs1_data = '0;
        end
        if (rs2 == '0) begin
            rs2_data = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rf_we_i) begin
            regs[rf_waddr_i] <= rf_wdata_i;
        end
    end

    ////////////////////
    // Load-use hazard
    ////////////////////

    // Immediate forms leave rs2 unused, stores still read it
    assign uses_rs2 = !ctrl.use_imm || ctrl.mem_we;
    assign stall    = instr_vld_q && ex_is_load_i && (ex_mem_rd_i != '0) &&
                      ((ex_mem_rd_i == rs1) || (uses_rs2 && ex_mem_rd_i == rs2));

    assign instr_ready_o = !hold_i && !stall;

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_vld_q <= 1'b0;
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= CTRL_NOP;
        end else if (!hold_i) begin
            if (!stall) begin
                instr_vld_q <= instr_valid_i;
            end
            // A stall sends a bubble into execute
            id_ex.valid <= instr_vld_q && !stall;
            id_ex.ctrl  <= ctrl;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i && instr_ready_o) begin
            instr_q <= instr_i;
        end
        if (!hold_i) begin
            id_ex.rd_addr  <= rd;
            id_ex.rs1_addr <= rs1;
            id_ex.rs2_addr <= rs2;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
        end else begin
            // Write-back drains during a freeze, so catch its result here
            if (rf_we_i && rf_waddr_i == id_ex.rs1_addr) begin
                id_ex.rs1_data <= rf_wdata_i;
            end
            if (rf_we_i && rf_waddr_i == id_ex.rs2_addr) begin
                id_ex.rs2_data <= rf_wdata_i;
            end
        end
    end

    // Write-back never targets x0
    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) rf_we_i |-> (rf_waddr_i != '0)
    );

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module execute_stage import core_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               hold_i,
    id_ex_if.consumer          id_ex,
    ex_mem_if.producer         ex_mem,
    // Forwarding from the memory stage
    input  logic [`REG_AW-1:0] fwd_mem_rd_i,
    input  logic               fwd_mem_wen_i,
    input  logic [`DATA_W-1:0] fwd_mem_data_i,
    // Forwarding from write-back
    input  logic [`REG_AW-1:0] rd_addr_wb_i,
    input  logic               reg_alu_wen_wb_i,
    input  logic               reg_mem_wen_wb_i,
    input  logic [`DATA_W-1:0] alu_result_wb_i,
    input  logic [`DATA_W-1:0] mem_rdata_wb_i,
    // Hazard report to decode
    output logic [`REG_AW-1:0] ex_rd_o,
    output logic               ex_is_load_o
);

    logic               wb_wen;
    logic [`DATA_W-1:0] wb_data;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b_reg;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_result;

    assign wb_wen  = reg_alu_wen_wb_i || reg_mem_wen_wb_i;
    assign wb_data = reg_mem_wen_wb_i ? mem_rdata_wb_i : alu_result_wb_i;

    // Youngest producer wins
    function automatic logic [`DATA_W-1:0] pick_operand(
        input logic [`REG_AW-1:0] addr,
        input logic [`DATA_W-1:0] reg_data
    );
        logic [`DATA_W-1:0] value;
        value = reg_data;
        if (fwd_mem_wen_i && fwd_mem_rd_i == addr) begin
            value = fwd_mem_data_i;
        end else if (wb_wen && rd_addr_wb_i == addr) begin
            value = wb_data;
        end
        return value;
    endfunction

    always_comb begin
        op_a     = pick_operand(id_ex.rs1_addr, id_ex.rs1_data);
        op_b_reg = pick_operand(id_ex.rs2_addr, id_ex.rs2_data);
        op_b     = id_ex.ctrl.use_imm ? id_ex.imm : op_b_reg;
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    assign ex_rd_o      = id_ex.rd_addr;
    assign ex_is_load_o = id_ex.valid && id_ex.ctrl.reg_mem_wen;

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= CTRL_NOP;
        end else if (!hold_i) begin
            ex_mem.valid <= id_ex.valid;
            ex_mem.ctrl  <= id_ex.ctrl;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            ex_mem.rd_addr    <= id_ex.rd_addr;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= op_b_reg;
        end
    end

endmodule

// File: rtl/mem_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module mem_stage import bus_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    ex_mem_if.consumer         ex_mem,
    output logic               hold_o,
    // Wishbone classic master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output logic [`DATA_W-1:0] wb_adr_o,
    output logic [`DATA_W-1:0] wb_dat_o,
    input  logic [`DATA_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i,
    // To write-back
    output logic [`REG_AW-1:0] rd_addr_mem_o,
    output logic [`DATA_W-1:0] alu_result_mem_o,
    output logic [`DATA_W-1:0] mem_rdata_mem_o,
    output logic               reg_alu_wen_mem_o,
    output logic               reg_mem_wen_mem_o,
    output logic               valid_mem_o,
    output logic               flush_wb_o,
    // Forwarding to execute
    output logic [`REG_AW-1:0] fwd_mem_rd_o,
    output logic               fwd_mem_wen_o,
    output logic [`DATA_W-1:0] fwd_mem_data_o
);

    wbm_state_e         state_q;
    bus_kind_e          kind;
    logic [`DATA_W-1:0] rdata_q;
    logic               err_q;

    always_comb begin
        if (!ex_mem.valid || !ex_mem.ctrl.mem_en) begin
            kind = BUS_NONE;
        end else if (ex_mem.ctrl.mem_we) begin
            kind = BUS_WRITE;
        end else begin
            kind = BUS_READ;
        end
    end

    // Freeze the front until the bus cycle has completed
    assign hold_o = (kind != BUS_NONE) && (state_q != WBM_DONE);

    ////////////////////
    // Bus master FSM
    ////////////////////

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= WBM_IDLE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            wb_we_o  <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            case (state_q)
                WBM_IDLE: begin
                    if (kind != BUS_NONE) begin
                        state_q  <= WBM_BUSY;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= (kind == BUS_WRITE);
                    end
                end
                WBM_BUSY: begin
                    if (wb_ack_i || wb_err_i) begin
                        state_q  <= WBM_DONE;
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        err_q    <= wb_err_i;
                    end
                end
                default: state_q <= WBM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == WBM_IDLE && kind != BUS_NONE) begin
            wb_adr_o <= ex_mem.alu_result;
            wb_dat_o <= ex_mem.store_data;
        end
        if (state_q == WBM_BUSY && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    ////////////////////
    // Write-back side
    ////////////////////

    assign rd_addr_mem_o     = ex_mem.rd_addr;
    assign alu_result_mem_o  = ex_mem.alu_result;
    assign mem_rdata_mem_o   = rdata_q;
    assign reg_alu_wen_mem_o = ex_mem.ctrl.reg_alu_wen;
    assign reg_mem_wen_mem_o = ex_mem.ctrl.reg_mem_wen;

    // Bubbles go out while the bus is busy
    assign valid_mem_o = ex_mem.valid && !hold_o;

    // Only a faulting load is squashed
    assign flush_wb_o = (state_q == WBM_DONE) && err_q && (kind == BUS_READ);

    assign fwd_mem_rd_o   = ex_mem.rd_addr;
    assign fwd_mem_wen_o  = ex_mem.valid && ex_mem.ctrl.reg_alu_wen;
    assign fwd_mem_data_o = ex_mem.alu_result;

    a_stb_in_cyc: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) wb_stb_o |-> wb_cyc_o
    );

    // Request is held until the slave answers
    a_adr_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (wb_stb_o && !wb_ack_i && !wb_err_i) |=> (wb_stb_o && $stable(wb_adr_o))
    );

endmodule

// File: rtl/wb_stage.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module wb_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // From the memory stage
    input  logic [`REG_AW-1:0] rd_addr_mem_i,
    input  logic [`DATA_W-1:0] alu_result_mem_i,
    input  logic [`DATA_W-1:0] mem_rdata_mem_i,
    input  logic               reg_alu_wen_mem_i,
    input  logic               reg_mem_wen_mem_i,
    input  logic               valid_mem_i,

    // Register file write
    output logic [`DATA_W-1:0] reg_wdata_wb_o,
    output logic               reg_wen_wb_o,

    // Forwarding to execute
    output logic [`REG_AW-1:0] rd_addr_wb_o,
    output logic [`DATA_W-1:0] alu_result_wb_o,
    output logic [`DATA_W-1:0] mem_rdata_wb_o,
    output logic               reg_alu_wen_wb_o,
    output logic               reg_mem_wen_wb_o,

    input  logic               flush_wb_i
);

    ////////////////////
    // MEM to WB register
    ////////////////////

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_alu_wen_wb_o <= 1'b0;
            reg_mem_wen_wb_o <= 1'b0;
        end else if (flush_wb_i) begin
            // Faulting load becomes a bubble
            reg_alu_wen_wb_o <= 1'b0;
            reg_mem_wen_wb_o <= 1'b0;
        end else begin
            reg_alu_wen_wb_o <= valid_mem_i && reg_alu_wen_mem_i;
            reg_mem_wen_wb_o <= valid_mem_i && reg_mem_wen_mem_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_addr_wb_o    <= rd_addr_mem_i;
        alu_result_wb_o <= alu_result_mem_i;
        mem_rdata_wb_o  <= mem_rdata_mem_i;
    end

    // Load data only when the load enable is set
    always_comb begin
        if (reg_mem_wen_wb_o) begin
            reg_wdata_wb_o = mem_rdata_wb_o;
        end else begin
            reg_wdata_wb_o = alu_result_wb_o;
        end
        reg_wen_wb_o = reg_alu_wen_wb_o || reg_mem_wen_wb_o;
    end

endmodule

// File: rtl/pipe_core.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module pipe_core (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Instruction stream
    input  logic [`DATA_W-1:0] instr_i,
    input  logic               instr_valid_i,
    output logic               instr_ready_o,
    // Wishbone classic master
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output logic [`DATA_W-1:0] wb_adr_o,
    output logic [`DATA_W-1:0] wb_dat_o,
    input  logic [`DATA_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i,
    // Retire trace
    output logic               rf_we_o,
    output logic [`REG_AW-1:0] rf_waddr_o,
    output logic [`DATA_W-1:0] rf_wdata_o
);

    logic               hold;
    logic [`REG_AW-1:0] ex_rd;
    logic               ex_is_load;

    logic [`REG_AW-1:0] fwd_mem_rd;
    logic               fwd_mem_wen;
    logic [`DATA_W-1:0] fwd_mem_data;

    logic [`REG_AW-1:0] rd_addr_mem;
    logic [`DATA_W-1:0] alu_result_mem;
    logic [`DATA_W-1:0] mem_rdata_mem;
    logic               reg_alu_wen_mem;
    logic               reg_mem_wen_mem;
    logic               valid_mem;
    logic               flush_wb;

    logic [`DATA_W-1:0] reg_wdata_wb;
    logic               reg_wen_wb;
    logic [`REG_AW-1:0] rd_addr_wb;
    logic [`DATA_W-1:0] alu_result_wb;
    logic [`DATA_W-1:0] mem_rdata_wb;
    logic               reg_alu_wen_wb;
    logic               reg_mem_wen_wb;

    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();

    decode_stage u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .hold_i        (hold),
        .rf_we_i       (reg_wen_wb),
        .rf_waddr_i    (rd_addr_wb),
        .rf_wdata_i    (reg_wdata_wb),
        .ex_mem_rd_i   (ex_rd),
        .ex_is_load_i  (ex_is_load),
        .id_ex         (u_id_ex.producer)
    );

    execute_stage u_execute (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .hold_i           (hold),
        .id_ex            (u_id_ex.consumer),
        .ex_mem           (u_ex_mem.producer),
        .fwd_mem_rd_i     (fwd_mem_rd),
        .fwd_mem_wen_i    (fwd_mem_wen),
        .fwd_mem_data_i   (fwd_mem_data),
        .rd_addr_wb_i     (rd_addr_wb),
        .reg_alu_wen_wb_i (reg_alu_wen_wb),
        .reg_mem_wen_wb_i (reg_mem_wen_wb),
        .alu_result_wb_i  (alu_result_wb),
        .mem_rdata_wb_i   (mem_rdata_wb),
        .ex_rd_o          (ex_rd),
        .ex_is_load_o     (ex_is_load)
    );

    mem_stage u_mem (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ex_mem            (u_ex_mem.consumer),
        .hold_o            (hold),
        .wb_cyc_o          (wb_cyc_o),
        .wb_stb_o          (wb_stb_o),
        .wb_we_o           (wb_we_o),
        .wb_adr_o          (wb_adr_o),
        .wb_dat_o          (wb_dat_o),
        .wb_dat_i          (wb_dat_i),
        .wb_ack_i          (wb_ack_i),
        .wb_err_i          (wb_err_i),
        .rd_addr_mem_o     (rd_addr_mem),
        .alu_result_mem_o  (alu_result_mem),
        .mem_rdata_mem_o   (mem_rdata_mem),
        .reg_alu_wen_mem_o (reg_alu_wen_mem),
        .reg_mem_wen_mem_o (reg_mem_wen_mem),
        .valid_mem_o       (valid_mem),
        .flush_wb_o        (flush_wb),
        .fwd_mem_rd_o      (fwd_mem_rd),
        .fwd_mem_wen_o     (fwd_mem_wen),
        .fwd_mem_data_o    (fwd_mem_data)
    );

    wb_stage u_wb (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .rd_addr_mem_i     (rd_addr_mem),
        .alu_result_mem_i  (alu_result_mem),
        .mem_rdata_mem_i   (mem_rdata_mem),
        .reg_alu_wen_mem_i (reg_alu_wen_mem),
        .reg_mem_wen_mem_i (reg_mem_wen_mem),
        .valid_mem_i       (valid_mem),
        .reg_wdata_wb_o    (reg_wdata_wb),
        .reg_wen_wb_o      (reg_wen_wb),
        .rd_addr_wb_o      (rd_addr_wb),
        .alu_result_wb_o   (alu_result_wb),
        .mem_rdata_wb_o    (mem_rdata_wb),
        .reg_alu_wen_wb_o  (reg_alu_wen_wb),
        .reg_mem_wen_wb_o  (reg_mem_wen_wb),
        .flush_wb_i        (flush_wb)
    );

    // Retire trace mirrors the register file write
    assign rf_we_o    = reg_wen_wb;
    assign rf_waddr_o = rd_addr_wb;
    assign rf_wdata_o = reg_wdata_wb;

endmodule

// File: tests/tb_pipe_core.sv
`timescale 1ns/10ps
`include "core_defs.svh"

module tb_pipe_core import core_pkg::*; ();

    logic               clk_i;
    logic               rst_n_i;
    logic [`DATA_W-1:0] instr_i;
    logic               instr_valid_i;
    logic               instr_ready_o;
    logic               wb_cyc_o;
    logic               wb_stb_o;
    logic               wb_we_o;
    logic [`DATA_W-1:0] wb_adr_o;
    logic [`DATA_W-1:0] wb_dat_o;
    logic [`DATA_W-1:0] wb_dat_i = '0;
    logic               wb_ack_i = 1'b0;
    logic               wb_err_i = 1'b0;
    logic               rf_we_o;
    logic [`REG_AW-1:0] rf_waddr_o;
    logic [`DATA_W-1:0] rf_wdata_o;

    logic [`DATA_W-1:0] mem [256];
    logic [`DATA_W-1:0] ref_mem [256];
    logic [`DATA_W-1:0] ref_regs [`NUM_REGS];
    logic [1:0]         delay_left = '0;

    logic [`DATA_W-1:0] prog [$];
    int                 test_first [$];
    string              test_name [$];
    logic [`REG_AW-1:0] exp_rd_q [$];
    logic [`DATA_W-1:0] exp_data_q [$];

    int err_count = 0;
    int checked_count = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    pipe_core u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    ////////////////////
    // Encoding and reference model
    ////////////////////

    function automatic logic [`DATA_W-1:0] enc(input opcode_e op, input int rd, input int rs1,
                                              input int rs2, input int imm);
        logic [`DATA_W-1:0] w;
        w = '0;
        w[`OPC_MSB:`OPC_LSB]   = op;
        w[`RD_LSB +: `REG_AW]  = rd[`REG_AW-1:0];
        w[`RS1_LSB +: `REG_AW] = rs1[`REG_AW-1:0];
        w[`RS2_LSB +: `REG_AW] = rs2[`REG_AW-1:0];
        w[`IMM_W-1:0]          = imm[`IMM_W-1:0];
        return w;
    endfunction

    // Every word differs, the index shows up in three bytes
    function automatic logic [`DATA_W-1:0] fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {8'hc3, a, ~a, a ^ 8'h5a};
    endfunction

    function automatic logic ref_step(input logic [`DATA_W-1:0] instr,
                                      output logic [`REG_AW-1:0] rd,
                                      output logic [`DATA_W-1:0] value);
        opcode_e            op;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [`DATA_W-1:0] imm;
        logic [`DATA_W-1:0] addr;
        logic               wr;
        op    = opcode_e'(instr[`OPC_MSB:`OPC_LSB]);
        rd    = instr[`RD_LSB +: `REG_AW];
        rs1   = instr[`RS1_LSB +: `REG_AW];
        rs2   = instr[`RS2_LSB +: `REG_AW];
        imm   = {{(`DATA_W-`IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};
        addr  = ref_regs[rs1] + imm;
        wr    = 1'b1;
        value = '0;
        case (op)
            OP_ADD:  value = ref_regs[rs1] + ref_regs[rs2];
            OP_SUB:  value = ref_regs[rs1] - ref_regs[rs2];
            OP_AND:  value = ref_regs[rs1] & ref_regs[rs2];
            OP_OR:   value = ref_regs[rs1] | ref_regs[rs2];
            OP_XOR:  value = ref_regs[rs1] ^ ref_regs[rs2];
            OP_ADDI: value = addr;
            OP_LW: begin
                // Words 240 and up answer with err, the load is dropped
                if ((addr >> 2) >= 32'd240) begin
                    wr = 1'b0;
                end else begin
                    value = ref_mem[addr[9:2]];
                end
            end
            OP_SW: begin
                if ((addr >> 2) < 32'd240) begin
                    ref_mem[addr[9:2]] = ref_regs[rs2];
                end
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (rd == '0) begin
            wr = 1'b0;
        end
        if (wr) begin
            ref_regs[rd] = value;
        end
        return wr;
    endfunction

    ////////////////////
    // Wishbone slave model
    ////////////////////

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_i   <= 1'b0;
            wb_err_i   <= 1'b0;
            delay_left <= '0;
        end else if (wb_ack_i || wb_err_i) begin
            wb_ack_i <= 1'b0;
            wb_err_i <= 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (delay_left != '0) begin
                delay_left <= delay_left - 2'd1;
            end else begin
                delay_left <= 2'($urandom_range(3, 0));
                if ((wb_adr_o >> 2) >= 32'd240) begin
                    wb_err_i <= 1'b1;
                end else begin
                    wb_ack_i <= 1'b1;
                    if (wb_we_o) begin
                        mem[wb_adr_o[9:2]] <= wb_dat_o;
                    end else begin
                        wb_dat_i <= mem[wb_adr_o[9:2]];
                    end
                end
            end
        end
    end

    ////////////////////
    // Retire checker
    ////////////////////

    always @(posedge clk_i) begin : compare
        logic [`REG_AW-1:0] exp_rd;
        logic [`DATA_W-1:0] exp_data;
        if (rst_n_i && rf_we_o) begin
            if (rf_waddr_o == '0) begin
                err_count++;
                $display("Register write to x0 appeared on the retire trace at %0t", $time);
            end
            if (exp_rd_q.size() == 0) begin
                err_count++;
                $display("Unexpected register write to x%0d at %0t, nothing was due to retire",
                         rf_waddr_o, $time);
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                checked_count++;
                if (rf_waddr_o !== exp_rd) begin
                    err_count++;
                    $display("FAIL t=%0t rf_waddr_o expected %0d got %0d",
                             $time, exp_rd, rf_waddr_o);
                end
                if (rf_wdata_o !== exp_data) begin
                    err_count++;
                    $display("FAIL t=%0t rf_wdata_o expected 0x%08h got 0x%08h",
                             $time, exp_data, rf_wdata_o);
                end
            end
        end
    end

    // Limit follows from the program length
    initial begin : watchdog
        @(posedge clk_i);
        while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the pipeline did not drain", cycle_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic emit(input opcode_e op, input int rd, input int rs1, input int rs2,
                        input int imm);
        prog.push_back(enc(op, rd, rs1, rs2, imm));
    endtask

    task automatic begin_test(input string name);
        test_first.push_back(prog.size());
        test_name.push_back(name);
    endtask

    task automatic build_programs();
        int      i;
        opcode_e op;
        int      rd;
        int      rs1;
        int      rs2;
        int      imm;
        begin_test("alu_basic");
        emit(OP_ADDI, 1, 0, 0, 100);
        emit(OP_ADDI, 2, 0, 0, -7);
        emit(OP_ADDI, 3, 0, 0, 2047);
        emit(OP_ADDI, 4, 0, 0, -2048);
        emit(OP_ADDI, 5, 0, 0, 'h55);
        emit(OP_ADDI, 6, 0, 0, 'hf0);
        emit(OP_ADDI, 7, 0, 0, 1);
        emit(OP_ADDI, 8, 0, 0, 3);
        emit(OP_ADD, 9, 1, 2, 0);
        emit(OP_SUB, 10, 3, 4, 0);
        emit(OP_AND, 11, 5, 6, 0);
        emit(OP_OR, 12, 5, 6, 0);
        emit(OP_XOR, 13, 5, 6, 0);
        begin_test("forwarding");
        emit(OP_ADD, 14, 1, 7, 0);
        emit(OP_SUB, 15, 14, 8, 0);
        emit(OP_XOR, 16, 14, 15, 0);
        emit(OP_ADDI, 14, 16, 0, 12);
        emit(OP_OR, 17, 14, 14, 0);
        emit(OP_AND, 18, 17, 16, 0);
        emit(OP_ADDI, 19, 18, 0, -1);
        begin_test("load_store");
        emit(OP_SW, 0, 0, 9, 16);
        emit(OP_LW, 20, 0, 0, 16);
        emit(OP_ADD, 21, 20, 1, 0);
        emit(OP_SW, 0, 0, 21, 20);
        emit(OP_LW, 22, 0, 0, 20);
        emit(OP_SW, 0, 0, 22, 24);
        emit(OP_LW, 23, 0, 0, 24);
        emit(OP_LW, 24, 0, 0, 32);
        emit(OP_XOR, 25, 23, 24, 0);
        begin_test("random_mix");
        for (i = 0; i < 24; i++) begin
            op  = opcode_e'($urandom_range(8, 0));
            rd  = $urandom_range(8, 0);
            rs1 = $urandom_range(8, 0);
            rs2 = $urandom_range(8, 0);
            imm = $urandom_range(4095, 0);
            if (op == OP_LW || op == OP_SW) begin
                rs1 = 0;
                imm = $urandom_range(15, 0) * 4;
            end
            emit(op, rd, rs1, rs2, imm);
        end
        begin_test("bus_error");
        emit(OP_ADDI, 26, 0, 0, 77);
        emit(OP_LW, 26, 0, 0, 960);
        emit(OP_ADD, 27, 26, 1, 0);
        emit(OP_SW, 0, 0, 1, 1020);
        emit(OP_LW, 28, 0, 0, 2000);
        emit(OP_ADDI, 29, 27, 0, 1);
        begin_test("x0_rules");
        emit(OP_ADDI, 0, 1, 0, 5);
        emit(OP_ADD, 0, 1, 2, 0);
        emit(OP_ADD, 30, 0, 1, 0);
        emit(OP_OR, 31, 0, 0, 0);
        emit(OP_LW, 0, 0, 0, 16);
        emit(OP_ADDI, 30, 0, 0, 0);
    endtask

    // Holds the instruction until the core takes it
    task automatic issue(input logic [`DATA_W-1:0] instr);
        logic               wr;
        logic [`REG_AW-1:0] rd;
        logic [`DATA_W-1:0] value;
        instr_i       <= instr;
        instr_valid_i <= 1'b1;
        @(posedge clk_i);
        while (!instr_ready_o) begin
            @(posedge clk_i);
        end
        wr = ref_step(instr, rd, value);
        if (wr) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(value);
        end
    endtask

    task automatic run_test(input int idx);
        int i;
        int last;
        int drain;
        int errs_before;
        int checked_before;
        errs_before    = err_count;
        checked_before = checked_count;
        drain          = 0;
        last = (idx + 1 < test_first.size()) ? test_first[idx+1] : prog.size();
        for (i = test_first[idx]; i < last; i++) begin
            issue(prog[i]);
        end
        instr_valid_i <= 1'b0;
        // Worst drain is four stages plus a few slow bus cycles
        while (exp_rd_q.size() != 0 && drain < 40) begin
            @(posedge clk_i);
            drain++;
        end
        // Four stages deep, so anything stray shows up within this window
        repeat (4) @(posedge clk_i);
        $display("test %0d %s: %0d writes checked, %0d errors", idx, test_name[idx],
                 checked_count - checked_before, err_count - errs_before);
    endtask

    initial begin : main
        int i;
        int missing;
        void'($urandom(32'h3f3c));
        rst_n_i       = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        missing       = 0;
        for (i = 0; i < 256; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (i = 0; i < `NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        build_programs();
        cycle_limit = prog.size() * 10 + 50;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (i = 0; i < test_name.size(); i++) begin
            run_test(i);
        end
        if (exp_rd_q.size() != 0) begin
            missing = exp_rd_q.size();
            $display("%0d expected register writes never retired", missing);
        end
        $display("tests %0d, writes checked %0d, errors %0d", test_name.size(),
                 checked_count, err_count + missing);
        if (err_count + missing == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
rtl/core_pkg.sv
rtl/bus_pkg.sv
rtl/stage_if.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/pipe_core.sv
tests/tb_pipe_core.sv
